// File: build.f
+incdir+src
src/space_pkg.sv
src/frame_control.sv
src/ship_motion.sv
src/laser_engine.sv
src/sprite_render.sv
src/spaceship.sv
test/tb_spaceship.sv

// File: run.sh
#!/bin/sh
# Compile and run the spaceship testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_spaceship -o sim_spaceship
output=$(./obj_dir/sim_spaceship)
echo "$output"
if echo "$output" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1

// File: src/frame_control.sv
`timescale 1ns/1ns
`default_nettype none

module frame_control (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  restart,
	input  space_pkg::game_mode_t mode,
	input  space_pkg::coord_t     pixel_x,
	input  space_pkg::coord_t     pixel_y,
	output logic                  frame_tick,
	output logic                  clear
);
	import space_pkg::*;

	logic at_origin;
	logic mode_cleared;
	logic mode_play;

	// First pixel of the frame marks the update point
	assign at_origin = (pixel_x == '0) && (pixel_y == '0);

	// Title and menu screens keep the player parked
	assign mode_cleared = (mode == MODE_TITLE) || (mode == MODE_MENU);
	assign mode_play = (mode == MODE_PLAY);

	// Clear from reset, restart or a parked mode
	// Downstream gives it priority over the tick
	assign clear = reset || restart || mode_cleared;

	// One update strobe per frame in play mode
	// Hold mode gets no strobe, so state freezes
	assign frame_tick = at_origin && mode_play;

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// No state update may leak out of play mode
	tick_only_in_play: assert property (
		@(posedge clk) disable iff (reset)
		frame_tick |-> (mode == MODE_PLAY)
	);

endmodule

`default_nettype wire

// File: src/laser_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "space_cfg.svh"

module laser_engine (
	input  logic                     clk,
	input  logic                     clear,
	input  logic                     frame_tick,
	input  logic                     button_shoot,
	input  space_pkg::coord_t        ship_x,
	input  space_pkg::coord_t        saucer_x,
	input  space_pkg::coord_t        saucer_y,
	input  space_pkg::alien_coords_t alien_x,
	input  space_pkg::alien_coords_t alien_y,
	output space_pkg::coord_t        laser_x,
	output space_pkg::coord_t        laser_y,
	output logic                     laser_active
);
	import space_pkg::*;

	// Laser stops once its centre reaches this row
	localparam coord_t SCOREBOARD_HIT_ROW =
		`SCOREBOARD_BOTTOM + `LASER_HEIGHT / 2 + `CLIMB_STEP;

	localparam coord_t SAUCER_HALF_H = `SAUCER_HEIGHT / 2;
	localparam coord_t SAUCER_HALF_L = `SAUCER_LENGTH / 2;
	localparam coord_t ALIEN_HALF_H  = `ALIEN_HEIGHT / 2;
	localparam coord_t ALIEN_HALF_L  = `ALIEN_LENGTH / 2;

	logic                   hit_scoreboard;
	logic                   hit_saucer;
	logic [`NUM_ALIENS-1:0] hit_alien;
	logic                   hit;

	// Laser under a target box and at or above its lower hit row
	// Sums wrap at 11 bits near zero
	function automatic logic in_hit_box(
		input coord_t lx,
		input coord_t ly,
		input coord_t tx,
		input coord_t ty,
		input coord_t half_h,
		input coord_t half_l
	);
		logic row_hit;
		logic col_hit;
		row_hit = (ly <= ty + half_h + `CLIMB_STEP);
		col_hit = (lx >= tx - half_l) && (lx <= tx + half_l);
		return row_hit && col_hit;
	endfunction

	////////////////////////////////////////////////////////////
	// Hit detection on the current position
	////////////////////////////////////////////////////////////

	assign hit_scoreboard = (laser_y <= SCOREBOARD_HIT_ROW);

	assign hit_saucer = in_hit_box(laser_x, laser_y, saucer_x, saucer_y,
		SAUCER_HALF_H, SAUCER_HALF_L);

	// Same box test for every alien slot
	for (genvar i = 0; i < `NUM_ALIENS; i++) begin : g_alien_hit
		assign hit_alien[i] = in_hit_box(laser_x, laser_y, alien_x[i], alien_y[i],
			ALIEN_HALF_H, ALIEN_HALF_L);
	end

	assign hit = hit_scoreboard || hit_saucer || (|hit_alien);

	////////////////////////////////////////////////////////////
	// Per-frame laser update
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (clear) begin
			laser_x      <= `SHIP_INITIAL;
			laser_y      <= `LASER_INITIAL_Y;
			laser_active <= 1'b0;
		end else if (frame_tick) begin
			if (!laser_active) begin
				// Launch from the ship centre
				if (button_shoot) begin
					laser_active <= 1'b1;
					laser_x      <= ship_x;
				end
			end else if (hit) begin
				// Back to the parked row above the ship
				laser_active <= 1'b0;
				laser_x      <= ship_x;
				laser_y      <= `LASER_INITIAL_Y;
			end else begin
				laser_y <= laser_y - `CLIMB_STEP;
			end
		end
	end

	// Scoreboard stop keeps a live laser from climbing past it
	laser_above_scoreboard: assert property (
		@(posedge clk) disable iff (clear)
		laser_active |-> (laser_y >= SCOREBOARD_HIT_ROW)
	);

endmodule

`default_nettype wire

// File: src/ship_motion.sv
`timescale 1ns/1ns
`default_nettype none

`include "space_cfg.svh"

module ship_motion (
	input  logic              clk,
	input  logic              clear,
	input  logic              frame_tick,
	input  logic              button_left,
	input  logic              button_right,
	output space_pkg::coord_t ship_x
);
	import space_pkg::*;

	// Centre limits keep the whole hull on screen
	localparam coord_t LEFT_LIMIT  = `LEFT_EDGE + `SHIP_LENGTH / 2;
	localparam coord_t RIGHT_LIMIT = `RIGHT_EDGE - `SHIP_LENGTH / 2;

	logic can_left;
	logic can_right;

	assign can_left = button_left && (ship_x > LEFT_LIMIT);
	assign can_right = button_right && (ship_x < RIGHT_LIMIT);

	always_ff @(posedge clk) begin
		if (clear) begin
			ship_x <= `SHIP_INITIAL;
		end else if (frame_tick) begin
			// Right is checked first, so it overrides left
			if (can_right) begin
				ship_x <= ship_x + `MOVE_STEP;
			end else if (can_left) begin
				ship_x <= ship_x - `MOVE_STEP;
			end
		end
	end

	// Hull never crosses an edge
	ship_in_bounds: assert property (
		@(posedge clk) disable iff (clear)
		(ship_x >= LEFT_LIMIT) && (ship_x <= RIGHT_LIMIT)
	);

endmodule

`default_nettype wire

// File: src/space_cfg.svh
`ifndef SPACE_CFG_SVH
`define SPACE_CFG_SVH

// Screen edges
`define LEFT_EDGE          11'd0
`define RIGHT_EDGE         11'd640
// Lowest row of the scoreboard band
`define SCOREBOARD_BOTTOM  11'd40

// Ship body rows and width, centre after clear
`define SHIP_TOP           11'd420
`define SHIP_BOTTOM        11'd430
`define SHIP_LENGTH        11'd40
`define SHIP_INITIAL       11'd320

// Laser sprite size and parked row, just above the ship
`define LASER_HEIGHT       11'd10
`define LASER_LENGTH       11'd3
`define LASER_INITIAL_Y    11'd417

// Hit boxes of the targets
`define SAUCER_HEIGHT      11'd15
`define SAUCER_LENGTH      11'd40
`define ALIEN_HEIGHT       11'd16
`define ALIEN_LENGTH       11'd30

// Per-frame steps
`define MOVE_STEP          11'd1
`define CLIMB_STEP         11'd1

// Colours packed as blue, green, red
`define COLOR_SHIP         8'h78
`define COLOR_LASER        8'hFF
`define COLOR_BLACK        8'h00

// Aliens checked for laser hits
`define NUM_ALIENS         4

`endif

// File: src/space_pkg.sv
`default_nettype none

`include "space_cfg.svh"

package space_pkg;

	// Raster coordinate, wide enough for 640 columns
	typedef logic [10:0] coord_t;

	// Blue in the top bits, red in the bottom
	typedef logic [7:0] color_t;

	// Title and menu keep the game cleared
	// Hold freezes everything in place
	typedef enum logic [1:0] {
		MODE_TITLE = 2'd0,
		MODE_MENU  = 2'd1,
		MODE_PLAY  = 2'd2,
		MODE_HOLD  = 2'd3
	} game_mode_t;

	// One coordinate per alien slot, slot 0 in the low bits
	typedef coord_t [`NUM_ALIENS-1:0] alien_coords_t;

endpackage

`default_nettype wire

// File: src/spaceship.sv
`timescale 1ns/1ns
`default_nettype none

module spaceship (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     restart,
	input  logic                     button_left,
	input  logic                     button_right,
	input  logic                     button_shoot,
	input  space_pkg::game_mode_t    mode,
	input  space_pkg::coord_t        pixel_x,
	input  space_pkg::coord_t        pixel_y,
	input  space_pkg::coord_t        saucer_x,
	input  space_pkg::coord_t        saucer_y,
	input  space_pkg::alien_coords_t alien_x,
	input  space_pkg::alien_coords_t alien_y,
	output logic                     is_spaceship,
	output space_pkg::color_t        rgb_spaceship,
	output logic                     is_laser,
	output space_pkg::color_t        rgb_laser,
	output space_pkg::coord_t        laser_x,
	output space_pkg::coord_t        laser_y
);
	import space_pkg::*;

	// Frame strobe and clear level
	logic   frame_tick;
	logic   clear;
	// Player state
	coord_t ship_x;
	logic   laser_active;

	frame_control i_frame_control (
		.clk        (clk),
		.reset      (reset),
		.restart    (restart),
		.mode       (mode),
		.pixel_x    (pixel_x),
		.pixel_y    (pixel_y),
		.frame_tick (frame_tick),
		.clear      (clear)
	);

	ship_motion i_ship_motion (
		.clk          (clk),
		.clear        (clear),
		.frame_tick   (frame_tick),
		.button_left  (button_left),
		.button_right (button_right),
		.ship_x       (ship_x)
	);

	// Laser position also feeds the other game objects
	laser_engine i_laser_engine (
		.clk          (clk),
		.clear        (clear),
		.frame_tick   (frame_tick),
		.button_shoot (button_shoot),
		.ship_x       (ship_x),
		.saucer_x     (saucer_x),
		.saucer_y     (saucer_y),
		.alien_x      (alien_x),
		.alien_y      (alien_y),
		.laser_x      (laser_x),
		.laser_y      (laser_y),
		.laser_active (laser_active)
	);

	sprite_render i_sprite_render (
		.laser_active  (laser_active),
		.pixel_x       (pixel_x),
		.pixel_y       (pixel_y),
		.ship_x        (ship_x),
		.laser_x       (laser_x),
		.laser_y       (laser_y),
		.is_spaceship  (is_spaceship),
		.rgb_spaceship (rgb_spaceship),
		.is_laser      (is_laser),
		.rgb_laser     (rgb_laser)
	);

endmodule

`default_nettype wire

// File: src/sprite_render.sv
`timescale 1ns/1ns
`default_nettype none

`include "space_cfg.svh"

module sprite_render (
	input  logic              laser_active,
	input  space_pkg::coord_t pixel_x,
	input  space_pkg::coord_t pixel_y,
	input  space_pkg::coord_t ship_x,
	input  space_pkg::coord_t laser_x,
	input  space_pkg::coord_t laser_y,
	output logic              is_spaceship,
	output space_pkg::color_t rgb_spaceship,
	output logic              is_laser,
	output space_pkg::color_t rgb_laser
);
	import space_pkg::*;

	// Half extents around each sprite centre
	localparam coord_t SHIP_HALF_L  = `SHIP_LENGTH / 2;
	localparam coord_t LASER_HALF_H = `LASER_HEIGHT / 2;
	localparam coord_t LASER_HALF_L = `LASER_LENGTH / 2;

	logic ship_rows;
	logic ship_cols;
	logic laser_rows;
	logic laser_cols;

	////////////////////////////////////////////////////////////
	// Ship hull
	////////////////////////////////////////////////////////////

	// Fixed band near the bottom of the screen
	assign ship_rows = (pixel_y >= `SHIP_TOP) && (pixel_y <= `SHIP_BOTTOM);
	assign ship_cols = (pixel_x >= ship_x - SHIP_HALF_L) &&
		(pixel_x <= ship_x + SHIP_HALF_L);

	assign is_spaceship = ship_rows && ship_cols;

	////////////////////////////////////////////////////////////
	// Laser bolt
	////////////////////////////////////////////////////////////

	// Thin vertical bar centred on the laser position
	assign laser_rows = (pixel_y >= laser_y - LASER_HALF_H) &&
		(pixel_y <= laser_y + LASER_HALF_H);
	assign laser_cols = (pixel_x >= laser_x - LASER_HALF_L) &&
		(pixel_x <= laser_x + LASER_HALF_L);

	// Parked laser stays invisible
	assign is_laser = laser_active && laser_rows && laser_cols;

	// Colours, black outside the sprite
	assign rgb_spaceship = is_spaceship ? `COLOR_SHIP : `COLOR_BLACK;
	assign rgb_laser = is_laser ? `COLOR_LASER : `COLOR_BLACK;

endmodule

`default_nettype wire

// File: test/tb_spaceship.sv
`timescale 1ns/1ns
`default_nettype none

module tb_spaceship;
	import space_pkg::*;

	logic          clk = 1'b0;
	logic          reset;
	logic          restart;
	logic          button_left;
	logic          button_right;
	logic          button_shoot;
	game_mode_t    mode;
	coord_t        pixel_x;
	coord_t        pixel_y;
	coord_t        saucer_x;
	coord_t        saucer_y;
	alien_coords_t alien_x;
	alien_coords_t alien_y;
	logic          is_spaceship;
	color_t        rgb_spaceship;
	logic          is_laser;
	color_t        rgb_laser;
	coord_t        laser_x;
	coord_t        laser_y;

	// Model of ship centre, laser centre and laser flag
	int   m_ship;
	int   m_lx;
	int   m_ly;
	logic m_act;
	int   errors;
	int   tests;
	int   test_start;
	int   seed;
	int   r;
	logic exp_ship;
	logic exp_laser;

	spaceship i_dut (.*);

	always #2 clk = ~clk;

	// Hull covers rows 420 to 430 and 20 columns either side of the centre
	function automatic logic ship_pixel(input int px, input int py, input int sx);
		return (py >= 420) && (py <= 430) && (px >= sx - 20) && (px <= sx + 20);
	endfunction

	// Bolt spans 5 rows and 1 column either side of its centre
	function automatic logic laser_pixel(input int px, input int py, input int lx,
		input int ly, input logic act);
		return act && (py >= ly - 5) && (py <= ly + 5) && (px >= lx - 1) && (px <= lx + 1);
	endfunction

	// Scoreboard at row 46 or a box of y + half height + climb and x +- half length
	function automatic logic laser_hits_target();
		logic hit;
		hit = (m_ly <= 46);
		if ((m_ly <= int'(saucer_y) + 8) && (m_lx >= int'(saucer_x) - 20) &&
				(m_lx <= int'(saucer_x) + 20)) begin
			hit = 1'b1;
		end
		for (int i = 0; i < 4; i++) begin
			if ((m_ly <= int'(alien_y[i]) + 9) && (m_lx >= int'(alien_x[i]) - 15) &&
					(m_lx <= int'(alien_x[i]) + 15)) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	assign exp_ship = ship_pixel(int'(pixel_x), int'(pixel_y), m_ship);
	assign exp_laser = laser_pixel(int'(pixel_x), int'(pixel_y), m_lx, m_ly, m_act);

	task automatic report_mismatch(input string name, input int got, input int exp);
		$display("FAIL %s got %h expected %h", name, got, exp);
		errors++;
	endtask

	////////////////////////////////////////////////////////////
	// Checks against the model on every cycle
	////////////////////////////////////////////////////////////

	laser_x_check: assert property (@(posedge clk) disable iff (reset)
		int'(laser_x) == m_lx)
		else report_mismatch("laser_x", int'($sampled(laser_x)), $sampled(m_lx));
	laser_y_check: assert property (@(posedge clk) disable iff (reset)
		int'(laser_y) == m_ly)
		else report_mismatch("laser_y", int'($sampled(laser_y)), $sampled(m_ly));
	ship_flag_check: assert property (@(posedge clk) disable iff (reset)
		is_spaceship == exp_ship)
		else report_mismatch("is_spaceship", int'($sampled(is_spaceship)),
			int'($sampled(exp_ship)));
	ship_rgb_check: assert property (@(posedge clk) disable iff (reset)
		rgb_spaceship == (exp_ship ? 8'h78 : 8'h00))
		else report_mismatch("rgb_spaceship", int'($sampled(rgb_spaceship)),
			$sampled(exp_ship) ? 32'h78 : 32'h0);
	laser_flag_check: assert property (@(posedge clk) disable iff (reset)
		is_laser == exp_laser)
		else report_mismatch("is_laser", int'($sampled(is_laser)),
			int'($sampled(exp_laser)));
	laser_rgb_check: assert property (@(posedge clk) disable iff (reset)
		rgb_laser == (exp_laser ? 8'hFF : 8'h00))
		else report_mismatch("rgb_laser", int'($sampled(rgb_laser)),
			$sampled(exp_laser) ? 32'hFF : 32'h0);

	task automatic model_clear();
		m_ship = 320;
		m_lx = 320;
		m_ly = 417;
		m_act = 1'b0;
	endtask

	// Laser sees the centre from before the move
	task automatic model_tick(input logic left, input logic right, input logic shoot);
		if (m_act) begin
			if (laser_hits_target()) begin
				m_act = 1'b0;
				m_lx = m_ship;
				m_ly = 417;
			end else begin
				m_ly = m_ly - 1;
			end
		end else if (shoot) begin
			m_act = 1'b1;
			m_lx = m_ship;
		end
		// Right overrides left
		if (right && (m_ship < 620)) begin
			m_ship++;
		end else if (left && (m_ship > 20)) begin
			m_ship--;
		end
	endtask

	task automatic run_frame(input logic left, input logic right, input logic shoot);
		pixel_x = 11'd0;
		pixel_y = 11'd0;
		button_left = left;
		button_right = right;
		button_shoot = shoot;
		@(posedge clk);
		#1;
		if (mode == MODE_PLAY) begin
			model_tick(left, right, shoot);
		end
		// Off the origin, so the tick lasts one cycle
		pixel_x = 11'd1;
		pixel_y = 11'd1;
		button_left = 1'b0;
		button_right = 1'b0;
		button_shoot = 1'b0;
	endtask

	task automatic probe_pixel(input int px, input int py);
		pixel_x = 11'(px);
		pixel_y = 11'(py);
		@(posedge clk);
		#1;
	endtask

	task automatic probe_hull_edges();
		probe_pixel(m_ship - 21, 425);
		probe_pixel(m_ship - 20, 425);
		probe_pixel(m_ship + 20, 425);
		probe_pixel(m_ship + 21, 425);
	endtask

	task automatic clear_cycle();
		@(posedge clk);
		#1;
		model_clear();
	endtask

	// Climb until parked at row 417 again with right held for the first frames
	task automatic fly_until_return(input int right_frames);
		int n;
		n = 0;
		run_frame(1'b0, 1'b1, 1'b0);
		while ((int'(laser_y) != 417) && (n < 600)) begin
			run_frame(1'b0, n < right_frames, 1'b0);
			probe_pixel(m_lx, m_ly);
			n++;
		end
		if (n >= 600) begin
			$display("Timeout: the laser never returned to the ship");
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("Test %0d %s: %0d errors", tests, name, errors - test_start);
		test_start = errors;
	endtask

	initial begin
		reset = 1'b1;
		restart = 1'b0;
		button_left = 1'b0;
		button_right = 1'b0;
		button_shoot = 1'b0;
		mode = MODE_PLAY;
		pixel_x = 11'd1;
		pixel_y = 11'd1;
		// Targets left of the ship's path
		saucer_x = 11'd150;
		saucer_y = 11'd100;
		for (int i = 0; i < 4; i++) begin
			alien_x[i] = 11'(60 + 40 * i);
			alien_y[i] = 11'd150;
		end
		errors = 0;
		tests = 0;
		test_start = 0;
		seed = 32'h57fd;
		model_clear();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// Sweep around the parked hull
		for (int y = 418; y <= 432; y++) begin
			for (int x = 296; x <= 344; x++) begin
				probe_pixel(x, y);
			end
		end
		finish_test("reset state");

		for (int f = 0; f < 200; f++) begin
			r = $random(seed);
			run_frame(r[0], r[1], 1'b0);
			probe_hull_edges();
		end
		// Long enough to reach the left edge from wherever the random walk ends
		repeat (600) run_frame(1'b1, 1'b0, 1'b0);
		probe_hull_edges();
		finish_test("movement and edge limits");

		run_frame(1'b0, 1'b0, 1'b1);
		repeat (5) run_frame(1'b0, 1'b1, 1'b0);
		mode = MODE_HOLD;
		repeat (5) run_frame(1'b1, 1'b0, 1'b1);
		probe_hull_edges();
		mode = MODE_MENU;
		clear_cycle();
		mode = MODE_PLAY;
		probe_hull_edges();
		run_frame(1'b0, 1'b1, 1'b1);
		run_frame(1'b0, 1'b1, 1'b0);
		restart = 1'b1;
		clear_cycle();
		restart = 1'b0;
		probe_hull_edges();
		finish_test("mode gating");

		run_frame(1'b0, 1'b0, 1'b1);
		repeat (3) run_frame(1'b0, 1'b1, 1'b0);
		// Second shot while in flight
		run_frame(1'b0, 1'b0, 1'b1);
		for (int y = m_ly - 6; y <= m_ly + 6; y++) begin
			for (int x = m_lx - 2; x <= m_lx + 2; x++) begin
				probe_pixel(x, y);
			end
		end
		finish_test("firing and climbing");

		// Open sky first, then saucer, then alien 2
		fly_until_return(30);
		saucer_x = 11'(m_ship);
		saucer_y = 11'd200;
		run_frame(1'b0, 1'b0, 1'b1);
		fly_until_return(30);
		saucer_x = 11'd150;
		saucer_y = 11'd100;
		alien_x[2] = 11'(m_ship);
		alien_y[2] = 11'd250;
		run_frame(1'b0, 1'b0, 1'b1);
		fly_until_return(30);
		finish_test("hits");

		$display("Tests run %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
